//--- bench/axi_rd_arbiter_tb.sv
`timescale 1ns/1ps

module axi_rd_arbiter_tb;

  localparam int max_req = 64;

  logic clk;
  logic rst_n;

  logic [axi_rd_pkg::num_m-1:0]                         s_axi_arvalid;
  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::id_w-1:0]   s_axi_arid;
  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::addr_w-1:0] s_axi_araddr;
  logic [axi_rd_pkg::num_m-1:0][7:0]                    s_axi_arlen;
  logic [axi_rd_pkg::num_m-1:0][2:0]                    s_axi_arsize;
  logic [axi_rd_pkg::num_m-1:0][1:0]                    s_axi_arburst;
  logic [axi_rd_pkg::num_m-1:0]                         s_axi_arready;
  logic [axi_rd_pkg::num_m-1:0]                         s_axi_rvalid;
  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::id_w-1:0]   s_axi_rid;
  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::data_w-1:0] s_axi_rdata;
  logic [axi_rd_pkg::num_m-1:0][1:0]                    s_axi_rresp;
  logic [axi_rd_pkg::num_m-1:0]                         s_axi_rlast;
  logic [axi_rd_pkg::num_m-1:0]                         s_axi_rready;

  logic                          m_axi_arvalid;
  logic [axi_rd_pkg::sid_w-1:0]  m_axi_arid;
  logic [axi_rd_pkg::addr_w-1:0] m_axi_araddr;
  logic [7:0]                    m_axi_arlen;
  logic [2:0]                    m_axi_arsize;
  logic [1:0]                    m_axi_arburst;
  logic                          m_axi_arready;
  logic                          m_axi_rvalid;
  logic [axi_rd_pkg::sid_w-1:0]  m_axi_rid;
  logic [axi_rd_pkg::data_w-1:0] m_axi_rdata;
  logic [1:0]                    m_axi_rresp;
  logic                          m_axi_rlast;
  logic                          m_axi_rready;

  // Request table from the stim file
  int st_batch [max_req];
  int st_m     [max_req];
  int st_id    [max_req];
  int st_addr  [max_req];
  int st_len   [max_req];
  int st_size  [max_req];
  int st_burst [max_req];
  int n_req;
  int total_beats;
  int exp_beats_m [axi_rd_pkg::num_m];

  // Grant order as seen by the masters
  int ar_order [max_req];
  int ar_wr;
  int m_order [axi_rd_pkg::num_m][max_req];
  int m_wr [axi_rd_pkg::num_m];

  // Slave model and R monitor state
  int s_sid  [max_req];
  int s_addr [max_req];
  int s_len  [max_req];
  int ar_seen;
  int ar_rd;
  int r_ptr;
  int r_k;
  int m_rd [axi_rd_pkg::num_m];
  int m_k [axi_rd_pkg::num_m];
  int beats_m [axi_rd_pkg::num_m];
  int beats_seen;

  axi_rd_arbiter axi_rd_arbiter_inst (.*);

  task automatic check_eq(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Fail at time %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "check failed");
    end
  endtask

  // First requester after the last winner
  function automatic int next_grant(input logic [axi_rd_pkg::num_m-1:0] pend, input int last);
    int c;
    for (int k = 1; k <= axi_rd_pkg::num_m; k++) begin
      c = (last + k) % axi_rd_pkg::num_m;
      if (pend[c]) begin
        return c;
      end
    end
    return -1;
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Slave AR/R drive and random master rready
  initial begin
    void'($urandom(32'haec));
    m_axi_arready = 1'b0;
    m_axi_rvalid  = 1'b0;
    m_axi_rid     = '0;
    m_axi_rdata   = '0;
    m_axi_rresp   = '0;
    m_axi_rlast   = 1'b0;
    s_axi_rready  = '0;
    forever begin
      @(negedge clk);
      m_axi_arready = ($urandom % 4) != 0;
      for (int i = 0; i < axi_rd_pkg::num_m; i++) begin
        s_axi_rready[i] = ($urandom % 4) != 0;
      end
      // Bursts return in request order and beat k carries address plus k
      if (r_ptr < ar_seen) begin
        m_axi_rvalid = 1'b1;
        m_axi_rid    = axi_rd_pkg::sid_w'(s_sid[r_ptr]);
        m_axi_rdata  = axi_rd_pkg::data_w'(s_addr[r_ptr] + r_k);
        m_axi_rlast  = (r_k == s_len[r_ptr]);
      end else begin
        m_axi_rvalid = 1'b0;
        m_axi_rlast  = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    int j;
    int idx;
    logic exp_v;
    if (!rst_n) begin
      ar_seen    = 0;
      ar_rd      = 0;
      r_ptr      = 0;
      r_k        = 0;
      beats_seen = 0;
      for (int i = 0; i < axi_rd_pkg::num_m; i++) begin
        m_rd[i]    = 0;
        m_k[i]     = 0;
        beats_m[i] = 0;
      end
    end else begin
      if (m_axi_rvalid && m_axi_rready) begin
        if (r_k == s_len[r_ptr]) begin
          r_ptr++;
          r_k = 0;
        end else begin
          r_k++;
        end
      end
      if (m_axi_arvalid && m_axi_arready) begin
        check_eq(int'(ar_rd < ar_wr), 1, "slave request without a master grant");
        j = ar_order[ar_rd];
        ar_rd++;
        check_eq(int'(m_axi_arid), (st_m[j] << axi_rd_pkg::id_w) | st_id[j], "slave arid");
        check_eq(int'(m_axi_araddr), st_addr[j], "slave araddr");
        check_eq(int'(m_axi_arlen), st_len[j], "slave arlen");
        check_eq(int'(m_axi_arsize), st_size[j], "slave arsize");
        check_eq(int'(m_axi_arburst), st_burst[j], "slave arburst");
        s_sid[ar_seen]  = int'(m_axi_arid);
        s_addr[ar_seen] = int'(m_axi_araddr);
        s_len[ar_seen]  = int'(m_axi_arlen);
        ar_seen++;
      end
      idx = int'(m_axi_rid) >> axi_rd_pkg::id_w;
      if (m_axi_rvalid && idx < axi_rd_pkg::num_m) begin
        check_eq(int'(m_axi_rready), int'(s_axi_rready[idx]), "rready routing");
      end
      for (int i = 0; i < axi_rd_pkg::num_m; i++) begin
        exp_v = m_axi_rvalid && (idx == i);
        check_eq(int'(s_axi_rvalid[i]), int'(exp_v), "rvalid routing");
        if (s_axi_rvalid[i] && s_axi_rready[i]) begin
          check_eq(int'(m_rd[i] < m_wr[i]), 1, "beat for a master with no open burst");
          j = m_order[i][m_rd[i]];
          check_eq(int'(s_axi_rid[i]), st_id[j], "master rid");
          check_eq(int'(s_axi_rdata[i]),
                   (st_addr[j] + m_k[i]) % (1 << axi_rd_pkg::data_w), "master rdata");
          check_eq(int'(s_axi_rresp[i]), 0, "master rresp");
          check_eq(int'(s_axi_rlast[i]), int'(m_k[i] == st_len[j]), "master rlast");
          beats_m[i]++;
          beats_seen++;
          if (m_k[i] == st_len[j]) begin
            m_rd[i]++;
            m_k[i] = 0;
          end else begin
            m_k[i]++;
          end
        end
      end
    end
  end

  // Watchdog sized from the beat count of the stim file
  initial begin
    int limit;
    wait (total_beats > 0);
    limit = 40 * total_beats + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int fd;
    int code;
    int j;
    int m;
    int exp_m;
    int cur_b;
    int rr_last;
    int b;
    int mm;
    int id;
    int a;
    int l;
    int s;
    int bu;
    int cur_j [axi_rd_pkg::num_m];
    string line;
    logic [axi_rd_pkg::num_m-1:0] pend;
    logic [axi_rd_pkg::num_m-1:0] acc;
    rst_n         = 1'b0;
    s_axi_arvalid = '0;
    s_axi_arid    = '0;
    s_axi_araddr  = '0;
    s_axi_arlen   = '0;
    s_axi_arsize  = '0;
    s_axi_arburst = '0;
    n_req       = 0;
    total_beats = 0;
    ar_wr       = 0;
    rr_last     = axi_rd_pkg::num_m - 1;
    for (int i = 0; i < axi_rd_pkg::num_m; i++) begin
      m_wr[i]        = 0;
      exp_beats_m[i] = 0;
    end
    fd = $fopen("bench/axi_rd_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/axi_rd_stim.txt");
      $display("Simulation failed");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      code = $sscanf(line, "%h %h %h %h %h %h %h", b, mm, id, a, l, s, bu);
      if (code == 7 && n_req < max_req) begin
        st_batch[n_req] = b;
        st_m[n_req]     = mm;
        st_id[n_req]    = id;
        st_addr[n_req]  = a;
        st_len[n_req]   = l;
        st_size[n_req]  = s;
        st_burst[n_req] = bu;
        total_beats     += l + 1;
        exp_beats_m[mm] += l + 1;
        n_req++;
      end
    end
    $fclose(fd);
    if (n_req == 0) begin
      $display("The stimulus file holds no read requests");
      $display("Simulation failed");
      $fatal(1, "empty stimulus");
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_eq(int'(m_axi_arvalid), 0, "arvalid after reset");
    check_eq(int'(s_axi_rvalid), 0, "rvalid after reset");
    check_eq(int'(s_axi_arready), 0, "arready after reset");

    j = 0;
    while (j < n_req) begin
      cur_b = st_batch[j];
      pend  = '0;
      @(negedge clk);
      while (j < n_req && st_batch[j] == cur_b) begin
        m                = st_m[j];
        cur_j[m]         = j;
        s_axi_arid[m]    = axi_rd_pkg::id_w'(st_id[j]);
        s_axi_araddr[m]  = axi_rd_pkg::addr_w'(st_addr[j]);
        s_axi_arlen[m]   = 8'(st_len[j]);
        s_axi_arsize[m]  = 3'(st_size[j]);
        s_axi_arburst[m] = 2'(st_burst[j]);
        pend[m]          = 1'b1;
        j++;
      end
      s_axi_arvalid = pend;
      while (pend != '0) begin
        @(posedge clk);
        check_eq(int'(s_axi_arready & ~s_axi_arvalid), 0, "arready without arvalid");
        acc = s_axi_arvalid & s_axi_arready;
        if (acc != '0) begin
          exp_m = next_grant(pend, rr_last);
          check_eq(int'(acc), 1 << exp_m, "round-robin grant");
          rr_last = exp_m;
          ar_order[ar_wr] = cur_j[exp_m];
          ar_wr++;
          m_order[exp_m][m_wr[exp_m]] = cur_j[exp_m];
          m_wr[exp_m]++;
          pend[exp_m] = 1'b0;
        end
        @(negedge clk);
        s_axi_arvalid = pend;
      end
    end

    while (beats_seen < total_beats) @(posedge clk);
    repeat (10) @(posedge clk);
    check_eq(ar_seen, n_req, "requests seen at the slave");
    check_eq(beats_seen, total_beats, "beats seen at the masters");
    for (int i = 0; i < axi_rd_pkg::num_m; i++) begin
      check_eq(beats_m[i], exp_beats_m[i], "beats per master");
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- bench/axi_rd_stim.txt
// batch master id addr len size burst, all hex
// one batch is issued together, each master at most once per batch
00 0 3 01000 0 1 1
01 1 5 02010 3 1 1
02 0 1 03000 1 1 1
02 1 2 04000 2 1 1
02 2 7 05000 0 1 1
03 0 a 06100 3 1 1
03 1 b 07200 1 1 2
03 2 c 08300 2 1 0
04 2 f 0fffe 3 1 1
04 0 0 10000 0 0 1
05 1 4 11110 7 1 1
05 2 6 12220 1 1 1
06 0 8 13330 2 1 1
06 1 9 14440 0 1 1
06 2 e 15550 5 1 1
07 2 1 16000 1 1 1
08 0 2 17000 4 1 1
08 1 3 18000 2 1 1
08 2 4 19000 3 1 1
09 1 d 1a000 0 1 1
09 2 5 1b000 2 2 1
0a 0 6 1c000 6 1 1
0a 1 7 1d000 1 1 1
0a 2 8 1e000 0 1 1
0b 0 9 1f000 2 1 1
0b 1 a 2a000 3 1 1
0c 0 b fffff 1 1 1
0c 2 c 80000 2 1 1

//--- compile.f
source/axi_rd_pkg.sv
source/rd_arb_ctrl.sv
source/ar_mux_reg.sv
source/r_route.sv
source/axi_rd_arbiter.sv
bench/axi_rd_arbiter_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the AXI read arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --timescale 1ns/1ps \
    -f compile.f --top-module axi_rd_arbiter_tb; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vaxi_rd_arbiter_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- source/ar_mux_reg.sv
`timescale 1ns/1ps

module ar_mux_reg (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 capture,
  input  logic [axi_rd_pkg::idx_w-1:0]                         grant_idx,
  input  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::addr_w-1:0] s_axi_araddr,
  input  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::id_w-1:0]   s_axi_arid,
  input  logic [axi_rd_pkg::num_m-1:0][7:0]                    s_axi_arlen,
  input  logic [axi_rd_pkg::num_m-1:0][2:0]                    s_axi_arsize,
  input  logic [axi_rd_pkg::num_m-1:0][1:0]                    s_axi_arburst,
  input  logic                                                 m_axi_arready,
  output logic                                                 m_axi_arvalid,
  output logic [axi_rd_pkg::sid_w-1:0]                         m_axi_arid,
  output logic [axi_rd_pkg::addr_w-1:0]                        m_axi_araddr,
  output logic [7:0]                                           m_axi_arlen,
  output logic [2:0]                                           m_axi_arsize,
  output logic [1:0]                                           m_axi_arburst,
  output logic                                                 ar_full,
  output logic                                                 ar_done
);

  assign ar_full = m_axi_arvalid;
  assign ar_done = m_axi_arvalid && m_axi_arready;

  // Valid holds until the slave accepts
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_axi_arvalid <= 1'b0;
    end else if (capture) begin
      m_axi_arvalid <= 1'b1;
    end else if (ar_done) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  // Load the granted master's request, index goes above its ID
  always_ff @(posedge clk) begin
    if (capture) begin
      m_axi_arid    <= {grant_idx, s_axi_arid[grant_idx]};
      m_axi_araddr  <= s_axi_araddr[grant_idx];
      m_axi_arlen   <= s_axi_arlen[grant_idx];
      m_axi_arsize  <= s_axi_arsize[grant_idx];
      m_axi_arburst <= s_axi_arburst[grant_idx];
    end
  end

endmodule

//--- source/axi_rd_arbiter.sv
`timescale 1ns/1ps

module axi_rd_arbiter (
  input  logic                                                 clk,
  input  logic                                                 rst_n,

  input  logic [axi_rd_pkg::num_m-1:0]                         s_axi_arvalid,
  input  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::id_w-1:0]   s_axi_arid,
  input  logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::addr_w-1:0] s_axi_araddr,
  input  logic [axi_rd_pkg::num_m-1:0][7:0]                    s_axi_arlen,
  input  logic [axi_rd_pkg::num_m-1:0][2:0]                    s_axi_arsize,
  input  logic [axi_rd_pkg::num_m-1:0][1:0]                    s_axi_arburst,
  output logic [axi_rd_pkg::num_m-1:0]                         s_axi_arready,
  output logic [axi_rd_pkg::num_m-1:0]                         s_axi_rvalid,
  output logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::id_w-1:0]   s_axi_rid,
  output logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::data_w-1:0] s_axi_rdata,
  output logic [axi_rd_pkg::num_m-1:0][1:0]                    s_axi_rresp,
  output logic [axi_rd_pkg::num_m-1:0]                         s_axi_rlast,
  input  logic [axi_rd_pkg::num_m-1:0]                         s_axi_rready,

  output logic                                                 m_axi_arvalid,
  output logic [axi_rd_pkg::sid_w-1:0]                         m_axi_arid,
  output logic [axi_rd_pkg::addr_w-1:0]                        m_axi_araddr,
  output logic [7:0]                                           m_axi_arlen,
  output logic [2:0]                                           m_axi_arsize,
  output logic [1:0]                                           m_axi_arburst,
  input  logic                                                 m_axi_arready,
  input  logic                                                 m_axi_rvalid,
  input  logic [axi_rd_pkg::sid_w-1:0]                         m_axi_rid,
  input  logic [axi_rd_pkg::data_w-1:0]                        m_axi_rdata,
  input  logic [1:0]                                           m_axi_rresp,
  input  logic                                                 m_axi_rlast,
  output logic                                                 m_axi_rready
);

  logic [axi_rd_pkg::idx_w-1:0] grant_idx;
  logic                         capture;
  logic                         ar_full;
  logic                         ar_done;

  rd_arb_ctrl rd_arb_ctrl_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (s_axi_arvalid),
    .ar_full  (ar_full),
    .ar_done  (ar_done),
    .grant_idx(grant_idx),
    .capture  (capture)
  );

  // Granted master sees arready in its capture cycle
  always_comb begin
    for (int i = 0; i < axi_rd_pkg::num_m; i++) begin
      s_axi_arready[i] = capture && (int'(grant_idx) == i);
    end
  end

  ar_mux_reg ar_mux_reg_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .capture      (capture),
    .grant_idx    (grant_idx),
    .s_axi_araddr (s_axi_araddr),
    .s_axi_arid   (s_axi_arid),
    .s_axi_arlen  (s_axi_arlen),
    .s_axi_arsize (s_axi_arsize),
    .s_axi_arburst(s_axi_arburst),
    .m_axi_arready(m_axi_arready),
    .m_axi_arvalid(m_axi_arvalid),
    .m_axi_arid   (m_axi_arid),
    .m_axi_araddr (m_axi_araddr),
    .m_axi_arlen  (m_axi_arlen),
    .m_axi_arsize (m_axi_arsize),
    .m_axi_arburst(m_axi_arburst),
    .ar_full      (ar_full),
    .ar_done      (ar_done)
  );

  r_route r_route_inst (
    .m_axi_rvalid(m_axi_rvalid),
    .m_axi_rid   (m_axi_rid),
    .m_axi_rdata (m_axi_rdata),
    .m_axi_rresp (m_axi_rresp),
    .m_axi_rlast (m_axi_rlast),
    .s_axi_rready(s_axi_rready),
    .m_axi_rready(m_axi_rready),
    .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rid   (s_axi_rid),
    .s_axi_rdata (s_axi_rdata),
    .s_axi_rresp (s_axi_rresp),
    .s_axi_rlast (s_axi_rlast)
  );

endmodule

//--- source/axi_rd_pkg.sv
package axi_rd_pkg;

  // Master count and index width
  localparam int num_m = 3;
  localparam int idx_w = 2;

  // AXI field widths
  localparam int addr_w = 20;
  localparam int data_w = 16;
  localparam int id_w   = 4;

  // Slave side ID carries the master index in its upper bits
  localparam int sid_w = id_w + idx_w;

  // Highest valid master index, so the first search after reset starts at 0
  localparam logic [idx_w-1:0] idx_last = idx_w'(num_m - 1);

  // Address phase state
  typedef enum logic {
    st_idle,
    st_busy
  } arb_state_e;

endpackage

//--- source/r_route.sv
`timescale 1ns/1ps

module r_route (
  input  logic                                                 m_axi_rvalid,
  input  logic [axi_rd_pkg::sid_w-1:0]                         m_axi_rid,
  input  logic [axi_rd_pkg::data_w-1:0]                        m_axi_rdata,
  input  logic [1:0]                                           m_axi_rresp,
  input  logic                                                 m_axi_rlast,
  input  logic [axi_rd_pkg::num_m-1:0]                         s_axi_rready,
  output logic                                                 m_axi_rready,
  output logic [axi_rd_pkg::num_m-1:0]                         s_axi_rvalid,
  output logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::id_w-1:0]   s_axi_rid,
  output logic [axi_rd_pkg::num_m-1:0][axi_rd_pkg::data_w-1:0] s_axi_rdata,
  output logic [axi_rd_pkg::num_m-1:0][1:0]                    s_axi_rresp,
  output logic [axi_rd_pkg::num_m-1:0]                         s_axi_rlast
);

  logic [axi_rd_pkg::idx_w-1:0] r_idx;

  // Master index sits in the upper ID bits
  assign r_idx = m_axi_rid[axi_rd_pkg::sid_w-1 -: axi_rd_pkg::idx_w];

  always_comb begin
    // Unknown index keeps ready high so the beat drains
    m_axi_rready = 1'b1;
    for (int i = 0; i < axi_rd_pkg::num_m; i++) begin
      s_axi_rvalid[i] = m_axi_rvalid && (int'(r_idx) == i);
      s_axi_rid[i]    = m_axi_rid[axi_rd_pkg::id_w-1:0];
      s_axi_rdata[i]  = m_axi_rdata;
      s_axi_rresp[i]  = m_axi_rresp;
      s_axi_rlast[i]  = m_axi_rlast;
      if (int'(r_idx) == i) begin
        m_axi_rready = s_axi_rready[i];
      end
    end
  end

endmodule

//--- source/rd_arb_ctrl.sv
`timescale 1ns/1ps

module rd_arb_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [axi_rd_pkg::num_m-1:0] req,
  input  logic                         ar_full,
  input  logic                         ar_done,
  output logic [axi_rd_pkg::idx_w-1:0] grant_idx,
  output logic                         capture
);

  axi_rd_pkg::arb_state_e state;

  logic [axi_rd_pkg::idx_w-1:0] last_idx;
  logic [axi_rd_pkg::idx_w-1:0] pick_idx;
  logic                         pick_valid;

  // Round-robin search, starting one past the last winner
  always_comb begin
    int cand;
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int k = 1; k <= axi_rd_pkg::num_m; k++) begin
      cand = (int'(last_idx) + k) % axi_rd_pkg::num_m;
      if (!pick_valid && req[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = cand[axi_rd_pkg::idx_w-1:0];
      end
    end
  end

  assign grant_idx = pick_idx;

  // Only grant when the AR register is free
  assign capture = (state == axi_rd_pkg::st_idle) && !ar_full && pick_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= axi_rd_pkg::st_idle;
      last_idx <= axi_rd_pkg::idx_last;
    end else begin
      case (state)
        axi_rd_pkg::st_idle: begin
          if (capture) begin
            state    <= axi_rd_pkg::st_busy;
            last_idx <= pick_idx;
          end
        end
        axi_rd_pkg::st_busy: begin
          // Slave took the request
          if (ar_done) begin
            state <= axi_rd_pkg::st_idle;
          end
        end
        default: begin
          state <= axi_rd_pkg::st_idle;
        end
      endcase
    end
  end

endmodule
